// File: sim/l2_trace.txt
// op (01 read, 02 write, ff end) _ address _ write line _ expected read line
// end entry: hit count in the write line field, miss count in the read line field
01_0000_00000000000000000000000000000000_00000000000000000000000000000000
01_0080_00000000000000000000000000000000_00800080008000800080008000800080
01_0100_00000000000000000000000000000000_01000100010001000100010001000100
01_0180_00000000000000000000000000000000_01800180018001800180018001800180
01_0200_00000000000000000000000000000000_02000200020002000200020002000200
01_0280_00000000000000000000000000000000_02800280028002800280028002800280
01_0300_00000000000000000000000000000000_03000300030003000300030003000300
01_0380_00000000000000000000000000000000_03800380038003800380038003800380
02_0000_0123456789abcdeffedcba9876543210_00000000000000000000000000000000
01_0000_00000000000000000000000000000000_0123456789abcdeffedcba9876543210
01_0400_00000000000000000000000000000000_04000400040004000400040004000400
01_0080_00000000000000000000000000000000_00800080008000800080008000800080
01_0200_00000000000000000000000000000000_02000200020002000200020002000200
01_0300_00000000000000000000000000000000_03000300030003000300030003000300
01_0180_00000000000000000000000000000000_01800180018001800180018001800180
01_0100_00000000000000000000000000000000_01000100010001000100010001000100
01_0000_00000000000000000000000000000000_0123456789abcdeffedcba9876543210
02_1234_a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0_00000000000000000000000000000000
01_1234_00000000000000000000000000000000_a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
01_00f0_00000000000000000000000000000000_00f000f000f000f000f000f000f000f0
ff_0000_00000000000000000000000000000014_0000000000000000000000000000000e

// File: list.f
common/l2_pkg.sv
common/l2_way_if.sv
l2_cache/l2_cache_control.sv
l2_cache/l2_tag_array.sv
l2_cache/l2_data_array.sv
l2_cache/l2_plru.sv
rtl/l2_cache.sv
sim/tb_l2_cache.sv

// File: run.sh
#!/bin/sh
# build and run the L2 cache testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
    --top-module tb_l2_cache -o tb_l2_cache_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/tb_l2_cache_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1

// File: sim/tb_l2_cache.sv
`timescale 1ns/1ns

module tb_l2_cache
    import l2_pkg::*;
();

    localparam int NUM_ENTRIES = 21;
    localparam int RESP_LIMIT  = 500;

    logic                 clk;
    logic                 rst;
    logic                 mem_read;
    logic                 mem_write;
    logic [ADDR_BITS-1:0] mem_address;
    logic [LINE_BITS-1:0] mem_wdata;
    logic                 mem_resp;
    logic [LINE_BITS-1:0] mem_rdata;
    logic                 pmem_read;
    logic                 pmem_write;
    logic [ADDR_BITS-1:0] pmem_address;
    logic [LINE_BITS-1:0] pmem_wdata;
    logic [LINE_BITS-1:0] pmem_rdata;
    logic                 pmem_resp;
    logic [15:0]          hit_count;
    logic [15:0]          miss_count;

    // op, address, write line, expected read line.
    logic [279:0] trace [0:NUM_ENTRIES-1];

    logic [LINE_BITS-1:0] phys [logic [15:0]];   // sparse physical memory.
    logic [31:0]          lfsr;
    logic                 busy;
    int                   delay_left;

    // reference cache of 8 sets by 8 ways.
    logic [8:0]           ref_tag [8][8];
    logic                 ref_valid [8][8];
    logic                 ref_dirty [8][8];
    logic [LINE_BITS-1:0] ref_line [8][8];
    logic [6:0]           ref_lru [8];
    int                   ref_hits;
    int                   ref_misses;

    logic                 exp_wb;
    logic                 exp_miss;
    logic [15:0]          exp_wb_addr;
    logic [LINE_BITS-1:0] exp_wb_data;
    logic [15:0]          exp_fill_addr;
    logic [LINE_BITS-1:0] exp_rdata;
    logic                 wb_seen;
    logic                 fill_seen;

    l2_cache #(.SET_BITS(3)) u_l2_cache (.*);

    always #5 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        repeat (2) begin
            d = d * 2 + int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // untouched lines hold their own address in every word.
    function automatic logic [LINE_BITS-1:0] line_at(input logic [15:0] a);
        if (phys.exists(a)) begin
            return phys[a];
        end
        return {8{a}};
    endfunction

    function automatic logic [2:0] lru_victim(input logic [6:0] bits);
        int         n;
        logic [2:0] w;
        n = 0;
        w = '0;
        repeat (3) begin
            w = {w[1:0], bits[n]};
            n = 2 * n + 1 + int'(bits[n]);
        end
        return w;
    endfunction

    function automatic logic [6:0] lru_touch(input logic [6:0] bits, input logic [2:0] w);
        int         n;
        logic [6:0] b;
        n = 0;
        b = bits;
        for (int lvl = 2; lvl >= 0; lvl--) begin
            b[n] = ~w[lvl];   // point away from the accessed side.
            n = 2 * n + 1 + int'(w[lvl]);
        end
        return b;
    endfunction

    task automatic predict(input logic is_write, input logic [15:0] a,
                           input logic [LINE_BITS-1:0] wdata);
        int         s;
        int         hw;
        logic [2:0] v;
        s = int'(a[6:4]);
        hw = -1;
        exp_wb = 1'b0;
        exp_miss = 1'b0;
        exp_fill_addr = {a[15:4], 4'h0};
        for (int i = 0; i < 8; i++) begin
            if (ref_valid[s][i] && ref_tag[s][i] == a[15:7]) begin
                hw = i;
            end
        end
        if (hw < 0) begin
            exp_miss = 1'b1;
            v = lru_victim(ref_lru[s]);
            if (ref_valid[s][v] && ref_dirty[s][v]) begin
                exp_wb = 1'b1;
                exp_wb_addr = {ref_tag[s][v], a[6:4], 4'h0};
                exp_wb_data = ref_line[s][v];
            end
            ref_line[s][v] = line_at(exp_fill_addr);
            ref_tag[s][v] = a[15:7];
            ref_valid[s][v] = 1'b1;
            ref_dirty[s][v] = 1'b0;
            hw = int'(v);
            ref_misses++;
        end
        ref_hits++;   // a miss is retried and then hits.
        exp_rdata = ref_line[s][hw];
        ref_lru[s] = lru_touch(ref_lru[s], 3'(hw));
        if (is_write) begin
            ref_line[s][hw] = wdata;
            ref_dirty[s][hw] = 1'b1;
        end
    endtask

    task automatic run_request(input logic [279:0] e);
        int cycles;
        predict(e[273], e[271:256], e[255:128]);
        if (e[272]) begin
            assert (exp_rdata == e[127:0])
                else fail_now($sformatf("Mismatch trace line: trace %h model %h",
                                        e[127:0], exp_rdata));
        end
        @(negedge clk);
        wb_seen = 1'b0;
        fill_seen = 1'b0;
        mem_read = e[272];
        mem_write = e[273];
        mem_address = e[271:256];
        mem_wdata = e[255:128];
        cycles = 0;
        #1;
        while (!mem_resp) begin
            @(negedge clk);
            #1;
            cycles++;
            assert (cycles < RESP_LIMIT)
                else fail_now($sformatf("timeout waiting for mem_resp at address %h",
                                        e[271:256]));
        end
        if (e[272]) begin
            assert (mem_rdata == e[127:0])
                else fail_now($sformatf("Mismatch mem_rdata: got %h expected %h",
                                        mem_rdata, e[127:0]));
        end
        assert (wb_seen == exp_wb)
            else fail_now("write-back presence differs from the victim's dirty state");
        assert (fill_seen == exp_miss)
            else fail_now("fill presence differs from the expected hit or miss");
        @(negedge clk);
        mem_read = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic check_pmem_start();
        assert (!(pmem_read && pmem_write))
            else fail_now("pmem_read and pmem_write raised together");
        if (pmem_write) begin
            assert (exp_wb) else fail_now("write-back of a clean victim");
            assert (pmem_address == exp_wb_addr)
                else fail_now($sformatf("Mismatch pmem_address: got %h expected %h",
                                        pmem_address, exp_wb_addr));
            assert (pmem_wdata == exp_wb_data)
                else fail_now($sformatf("Mismatch pmem_wdata: got %h expected %h",
                                        pmem_wdata, exp_wb_data));
            wb_seen = 1'b1;
        end else begin
            assert (pmem_address == exp_fill_addr)
                else fail_now($sformatf("Mismatch pmem_address: got %h expected %h",
                                        pmem_address, exp_fill_addr));
            fill_seen = 1'b1;
        end
    endtask

    // physical memory answers each request after 1 to 4 cycles.
    always @(negedge clk) begin
        if (rst) begin
            pmem_resp = 1'b0;
            busy = 1'b0;
        end else if (pmem_resp) begin
            pmem_resp = 1'b0;
        end else if (busy) begin
            if (delay_left == 0) begin
                if (pmem_write) begin
                    phys[pmem_address] = pmem_wdata;
                end else begin
                    pmem_rdata = line_at(pmem_address);
                end
                pmem_resp = 1'b1;
                busy = 1'b0;
            end else begin
                delay_left--;
            end
        end else if (pmem_read || pmem_write) begin
            check_pmem_start();
            busy = 1'b1;
            draw_delay(delay_left);
        end
    end

    initial begin
        int idx;
        clk = 1'b0;
        rst = 1'b1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        pmem_rdata = '0;
        pmem_resp = 1'b0;
        busy = 1'b0;
        delay_left = 0;
        lfsr = 32'h1284_5a95;
        ref_hits = 0;
        ref_misses = 0;
        for (int s = 0; s < 8; s++) begin
            ref_lru[s] = '0;
            for (int w = 0; w < 8; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
                ref_tag[s][w] = '0;
                ref_line[s][w] = '0;
            end
        end
        $readmemh("sim/l2_trace.txt", trace);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (!mem_resp)
                else fail_now("Mismatch mem_resp: got 1 expected 0 with no request");
            assert (!pmem_read)
                else fail_now("Mismatch pmem_read: got 1 expected 0 with no request");
            assert (!pmem_write)
                else fail_now("Mismatch pmem_write: got 1 expected 0 with no request");
            assert (hit_count == 16'h0)
                else fail_now($sformatf("Mismatch hit_count: got %h expected 0000",
                                        hit_count));
            assert (miss_count == 16'h0)
                else fail_now($sformatf("Mismatch miss_count: got %h expected 0000",
                                        miss_count));
        end
        idx = 0;
        while (trace[idx][279:272] != 8'hff) begin
            run_request(trace[idx]);
            idx++;
            assert (idx < NUM_ENTRIES) else fail_now("trace has no end entry");
        end
        @(negedge clk);
        assert (trace[idx][143:128] == 16'(ref_hits) && trace[idx][15:0] == 16'(ref_misses))
            else fail_now($sformatf("Mismatch trace counts: trace %h/%h model %h/%h",
                                    trace[idx][143:128], trace[idx][15:0],
                                    16'(ref_hits), 16'(ref_misses)));
        assert (hit_count == trace[idx][143:128])
            else fail_now($sformatf("Mismatch hit_count: got %h expected %h",
                                    hit_count, trace[idx][143:128]));
        assert (miss_count == trace[idx][15:0])
            else fail_now($sformatf("Mismatch miss_count: got %h expected %h",
                                    miss_count, trace[idx][15:0]));
        $display("TB PASSED");
        $finish;
    end

endmodule : tb_l2_cache

// File: rtl/l2_cache.sv
`timescale 1ns/1ns

module l2_cache
    import l2_pkg::*;
#(
    parameter int SET_BITS = 3
) (
    input  logic                 clk,
    input  logic                 rst,

    // arbiter side.
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic [ADDR_BITS-1:0] mem_address,
    input  logic [LINE_BITS-1:0] mem_wdata,
    output logic                 mem_resp,
    output logic [LINE_BITS-1:0] mem_rdata,

    // physical memory side.
    output logic                 pmem_read,
    output logic                 pmem_write,
    output logic [ADDR_BITS-1:0] pmem_address,
    output logic [LINE_BITS-1:0] pmem_wdata,
    input  logic [LINE_BITS-1:0] pmem_rdata,
    input  logic                 pmem_resp,

    output logic [15:0]          hit_count,
    output logic [15:0]          miss_count
);

    localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;

    logic                hit;
    logic [WAY_BITS-1:0] hit_way;
    logic [WAY_BITS-1:0] victim;
    logic                victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
    logic [LINE_BITS-1:0] line_out;

    l2_way_if way ();

    // the selected line serves both read data and write-back data.
    assign mem_rdata  = line_out;
    assign pmem_wdata = line_out;

    l2_cache_control #(.SET_BITS(SET_BITS)) u_control (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim       (victim),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .pmem_resp    (pmem_resp),
        .mem_resp     (mem_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .hit_count    (hit_count),
        .miss_count   (miss_count),
        .way          (way)
    );

    l2_tag_array #(.SET_BITS(SET_BITS)) u_tag_array (
        .clk          (clk),
        .rst          (rst),
        .mem_address  (mem_address),
        .victim       (victim),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .way          (way)
    );

    l2_data_array #(.SET_BITS(SET_BITS)) u_data_array (
        .clk         (clk),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .pmem_rdata  (pmem_rdata),
        .line_out    (line_out),
        .way         (way)
    );

    l2_plru #(.SET_BITS(SET_BITS)) u_plru (
        .clk         (clk),
        .rst         (rst),
        .mem_address (mem_address),
        .victim      (victim),
        .way         (way)
    );

endmodule : l2_cache

// File: l2_cache/l2_plru.sv
`timescale 1ns/1ns

module l2_plru
    import l2_pkg::*;
#(
    parameter int SET_BITS = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [ADDR_BITS-1:0] mem_address,
    output logic [WAY_BITS-1:0]  victim,
    l2_way_if.array              way
);

    localparam int NUM_SETS = 2 ** SET_BITS;

    logic [LRU_BITS-1:0] lru [NUM_SETS];
    logic [SET_BITS-1:0] set_idx;
    logic [LRU_BITS-1:0] cur;
    logic [LRU_BITS-1:0] updated;

    assign set_idx = mem_address[OFFSET_BITS +: SET_BITS];
    assign cur     = lru[set_idx];

    // walk from the root. bit 0 picks the half, bits 1..2 the pair, bits 3..6 the way.
    always_comb begin
        victim[2] = cur[0];
        victim[1] = cur[1 + victim[2]];
        victim[0] = cur[3 + victim[2:1]];
    end

    // every node on the accessed path is turned away from it.
    always_comb begin
        updated                         = cur;
        updated[0]                      = ~way.way_sel[2];
        updated[1 + way.way_sel[2]]     = ~way.way_sel[1];
        updated[3 + way.way_sel[2:1]]   = ~way.way_sel[0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                lru[s] <= '0;
            end
        end else if (way.touch) begin
            lru[set_idx] <= updated;
        end
    end

endmodule : l2_plru

// File: l2_cache/l2_data_array.sv
`timescale 1ns/1ns

module l2_data_array
    import l2_pkg::*;
#(
    parameter int SET_BITS = 3
) (
    input  logic                 clk,
    input  logic [ADDR_BITS-1:0] mem_address,
    input  logic [LINE_BITS-1:0] mem_wdata,
    input  logic [LINE_BITS-1:0] pmem_rdata,
    output logic [LINE_BITS-1:0] line_out,
    l2_way_if.array              way
);

    localparam int NUM_SETS = 2 ** SET_BITS;

    logic [LINE_BITS-1:0] lines [NUM_SETS][NUM_WAYS];
    logic [SET_BITS-1:0]  set_idx;
    logic [LINE_BITS-1:0] line_in;

    assign set_idx = mem_address[OFFSET_BITS +: SET_BITS];

    // fills take the memory line, write hits take the whole request line.
    assign line_in = way.fill ? pmem_rdata : mem_wdata;

    always_ff @(posedge clk) begin
        if (way.load_line) begin
            lines[set_idx][way.way_sel] <= line_in;
        end
    end

    assign line_out = lines[set_idx][way.way_sel];   // read is combinational.

endmodule : l2_data_array

// File: l2_cache/l2_tag_array.sv
`timescale 1ns/1ns

module l2_tag_array
    import l2_pkg::*;
#(
    parameter int SET_BITS = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [ADDR_BITS-1:0] mem_address,
    input  logic [WAY_BITS-1:0]  victim,
    output logic                 hit,
    output logic [WAY_BITS-1:0]  hit_way,
    output logic                 victim_dirty,
    output logic [ADDR_BITS-SET_BITS-OFFSET_BITS-1:0] victim_tag,
    l2_way_if.array              way
);

    localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;
    localparam int NUM_SETS = 2 ** SET_BITS;

    logic [TAG_BITS-1:0] tags [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty [NUM_SETS];

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] req_tag;

    assign set_idx = mem_address[OFFSET_BITS +: SET_BITS];
    assign req_tag = mem_address[ADDR_BITS-1 -: TAG_BITS];

    // at most one way can match, so a plain priority scan encodes it.
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (valid[set_idx][i] && tags[set_idx][i] == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(i);
            end
        end
    end

    assign victim_dirty = dirty[set_idx][victim];
    assign victim_tag   = tags[set_idx][victim];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (way.load_tag) begin
                valid[set_idx][way.way_sel] <= way.valid_in;
            end
            if (way.load_dirty) begin
                dirty[set_idx][way.way_sel] <= way.dirty_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (way.load_tag) begin
            tags[set_idx][way.way_sel] <= req_tag;
        end
    end

endmodule : l2_tag_array

// File: l2_cache/l2_cache_control.sv
`timescale 1ns/1ns

module l2_cache_control
    import l2_pkg::*;
#(
    parameter int SET_BITS = 3
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic [ADDR_BITS-1:0] mem_address,
    output logic                 mem_resp,

    // status from the tag array and LRU.
    input  logic                 hit,
    input  logic [WAY_BITS-1:0]  hit_way,
    input  logic [WAY_BITS-1:0]  victim,
    input  logic                 victim_dirty,
    input  logic [ADDR_BITS-SET_BITS-OFFSET_BITS-1:0] victim_tag,

    input  logic                 pmem_resp,
    output logic                 pmem_read,
    output logic                 pmem_write,
    output logic [ADDR_BITS-1:0] pmem_address,

    output logic [15:0]          hit_count,
    output logic [15:0]          miss_count,

    l2_way_if.ctl                way
);

    localparam logic [2:0] IDLE       = 3'd0;
    localparam logic [2:0] WRITE_BACK = 3'd1;
    localparam logic [2:0] FILL       = 3'd2;
    localparam logic [2:0] RECOVER_1  = 3'd3;
    localparam logic [2:0] RECOVER_2  = 3'd4;

    logic [2:0]           state;
    logic [2:0]           next_state;
    logic                 req;
    logic [SET_BITS-1:0]  set_idx;
    logic [ADDR_BITS-1:0] line_addr;
    logic [ADDR_BITS-1:0] victim_addr;

    assign req     = mem_read ^ mem_write;   // both at once is ignored.
    assign set_idx = mem_address[OFFSET_BITS +: SET_BITS];

    assign line_addr   = {mem_address[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign victim_addr = {victim_tag, set_idx, {OFFSET_BITS{1'b0}}};

    always_comb begin
        next_state      = state;
        mem_resp        = 1'b0;
        pmem_read       = 1'b0;
        pmem_write      = 1'b0;
        way.way_sel     = victim;   // write-back reads and fill writes the victim.
        way.load_tag    = 1'b0;
        way.valid_in    = 1'b0;
        way.dirty_in    = 1'b0;
        way.load_dirty  = 1'b0;
        way.fill        = 1'b0;
        way.load_line   = 1'b0;
        way.touch       = 1'b0;

        case (state)
            IDLE: begin
                way.way_sel = hit_way;
                if (req && hit) begin
                    mem_resp  = 1'b1;
                    way.touch = 1'b1;
                    if (mem_write) begin
                        way.load_line  = 1'b1;
                        way.dirty_in   = 1'b1;
                        way.load_dirty = 1'b1;
                    end
                    next_state = RECOVER_1;
                end else if (req) begin
                    next_state = victim_dirty ? WRITE_BACK : FILL;
                end
            end
            WRITE_BACK: begin
                pmem_write = 1'b1;
                if (pmem_resp) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    // new line lands clean, request retried from idle.
                    way.load_line  = 1'b1;
                    way.fill       = 1'b1;
                    way.load_tag   = 1'b1;
                    way.valid_in   = 1'b1;
                    way.load_dirty = 1'b1;
                    next_state     = IDLE;
                end
            end
            RECOVER_1: next_state = RECOVER_2;
            RECOVER_2: next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            state <= next_state;
            if (state == IDLE && req) begin
                if (hit) begin
                    hit_count <= hit_count + 16'd1;
                end else begin
                    miss_count <= miss_count + 16'd1;
                end
            end
        end
    end

    // memory address is set up a cycle ahead of pmem_read and pmem_write.
    always_ff @(posedge clk) begin
        if (state == IDLE && req && !hit) begin
            pmem_address <= victim_dirty ? victim_addr : line_addr;
        end else if (state == WRITE_BACK && pmem_resp) begin
            pmem_address <= line_addr;
        end
    end

endmodule : l2_cache_control

// File: common/l2_way_if.sv
`timescale 1ns/1ns

// per-access way commands from the controller to the tag array, data array and LRU.
interface l2_way_if
    import l2_pkg::*;
();

    logic [WAY_BITS-1:0] way_sel;   // way being accessed this cycle.
    logic                load_tag;  // write tag and valid bit.
    logic                valid_in;
    logic                dirty_in;
    logic                load_dirty;
    logic                fill;      // line comes from physical memory, not the request.
    logic                load_line;
    logic                touch;     // update the pseudo-LRU of the set.

    modport ctl (
        output way_sel, load_tag, valid_in, dirty_in, load_dirty,
        output fill, load_line, touch
    );

    modport array (
        input way_sel, load_tag, valid_in, dirty_in, load_dirty,
        input fill, load_line, touch
    );

endinterface : l2_way_if

// File: common/l2_pkg.sv
// geometry of the L2 cache shared by the controller, the arrays and the LRU.
package l2_pkg;

    // processor physical address.
    localparam int ADDR_BITS = 16;

    // one cache line as transferred by the L1 arbiter and physical memory.
    localparam int LINE_BITS = 128;

    // byte offset inside a line of 16 bytes.
    localparam int OFFSET_BITS = 4;

    // associativity.
    localparam int NUM_WAYS = 8;
    localparam int WAY_BITS = 3;   // log2 of NUM_WAYS.

    // tree pseudo-LRU with NUM_WAYS - 1 node bits per set.
    localparam int LRU_BITS = 7;

endpackage : l2_pkg
